// ==== src/stopwatch_pkg.sv ====
package stopwatch_pkg;

  // one decimal digit
  typedef logic [3:0] bcd_t;

  localparam bcd_t BCD_NINE = 4'd9; // limit of the ones digits
  localparam bcd_t BCD_FIVE = 4'd5; // limit of the tens digits

  // mm:ss with the most significant digit first
  typedef struct packed {
    bcd_t min_tens;
    bcd_t min_ones;
    bcd_t sec_tens;
    bcd_t sec_ones;
  } time_bcd_t;

  // raw levels or one-cycle strobes
  typedef struct packed {
    logic start_stop;
    logic lap_reset;
  } buttons_t;

  typedef struct packed {
    logic count_en; // digits may advance
    logic clear;    // one-cycle zeroing strobe
    logic lap_hold; // display frozen on lap value
  } ctrl_t;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    LAP  = 2'd2,
    STOP = 2'd3
  } sw_state_t;

  // one count step per second at 50 MHz
  localparam int TICK_DIV_DEFAULT = 50_000_000;

endpackage

// ==== src/bcd_digit_counter.sv ====
module bcd_digit_counter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clear,
  input  logic                carry_in,
  input  stopwatch_pkg::bcd_t limit,
  output stopwatch_pkg::bcd_t q,
  output logic                carry_out
);

  logic at_limit;

  assign at_limit  = (q == limit);
  assign carry_out = carry_in & at_limit; // wrap this cycle, bump next digit

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (clear) begin
      q <= '0;
    end else if (carry_in) begin
      if (at_limit) begin
        q <= '0;
      end else begin
        q <= q + 1'b1;
      end
    end
  end

endmodule

// ==== src/lap_counter.sv ====
module lap_counter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tick,
  input  stopwatch_pkg::ctrl_t     ctrl,
  output stopwatch_pkg::time_bcd_t display
);

  import stopwatch_pkg::*;

  time_bcd_t live;      // running count
  time_bcd_t hold;      // lap snapshot
  logic      saturated;
  logic      step;
  logic      carry_sec_ones;
  logic      carry_sec_tens;
  logic      carry_min_ones;

  assign saturated = (live.min_tens == BCD_FIVE) && (live.min_ones == BCD_NINE) &&
                     (live.sec_tens == BCD_FIVE) && (live.sec_ones == BCD_NINE);

  assign step = tick & ctrl.count_en & ~saturated; // stop at 59:59

  bcd_digit_counter u_sec_ones (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (ctrl.clear),
    .carry_in  (step),
    .limit     (BCD_NINE),
    .q         (live.sec_ones),
    .carry_out (carry_sec_ones)
  );

  bcd_digit_counter u_sec_tens (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (ctrl.clear),
    .carry_in  (carry_sec_ones),
    .limit     (BCD_FIVE),
    .q         (live.sec_tens),
    .carry_out (carry_sec_tens)
  );

  bcd_digit_counter u_min_ones (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (ctrl.clear),
    .carry_in  (carry_sec_tens),
    .limit     (BCD_NINE),
    .q         (live.min_ones),
    .carry_out (carry_min_ones)
  );

  // top digit never carries since saturation stops it first
  bcd_digit_counter u_min_tens (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (ctrl.clear),
    .carry_in  (carry_min_ones),
    .limit     (BCD_FIVE),
    .q         (live.min_tens),
    .carry_out ()
  );

  // follows the display, so it keeps itself once lap_hold is up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold <= '0;
    end else begin
      hold <= display;
    end
  end

  assign display = ctrl.lap_hold ? hold : live;

endmodule

// ==== src/button_pulse.sv ====
module button_pulse (
  input  logic                    clk,
  input  logic                    rst_n,
  input  stopwatch_pkg::buttons_t level,
  output stopwatch_pkg::buttons_t press
);

  import stopwatch_pkg::*;

  buttons_t meta; // first sync stage
  buttons_t sync; // second sync stage
  buttons_t prev; // sync delayed one cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta <= '0;
      sync <= '0;
      prev <= '0;
    end else begin
      meta <= level;
      sync <= meta;
      prev <= sync;
    end
  end

  // registered rising-edge strobe, one per button
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      press <= '0;
    end else begin
      press <= sync & ~prev;
    end
  end

endmodule

// ==== src/stopwatch_ctrl.sv ====
module stopwatch_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  stopwatch_pkg::buttons_t press,
  output stopwatch_pkg::ctrl_t    ctrl
);

  import stopwatch_pkg::*;

  sw_state_t state;
  sw_state_t state_nxt;
  logic      clear_q;
  logic      do_clear;

  always_comb begin
    state_nxt = state;
    do_clear  = 1'b0;
    case (state)
      IDLE: begin
        if (press.start_stop) state_nxt = RUN; // lap_reset ignored here
      end
      RUN: begin
        if (press.start_stop) begin
          state_nxt = STOP;
        end else if (press.lap_reset) begin
          state_nxt = LAP;
        end
      end
      LAP: begin
        if (press.start_stop) begin
          state_nxt = STOP; // release hold, show stopped time
        end else if (press.lap_reset) begin
          state_nxt = RUN;
        end
      end
      STOP: begin
        if (press.start_stop) begin
          state_nxt = RUN;
        end else if (press.lap_reset) begin
          state_nxt = IDLE;
          do_clear  = 1'b1;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      clear_q <= 1'b0;
    end else begin
      state   <= state_nxt;
      clear_q <= do_clear; // lines up with the new IDLE state
    end
  end

  assign ctrl.count_en = (state == RUN) || (state == LAP);
  assign ctrl.lap_hold = (state == LAP);
  assign ctrl.clear    = clear_q;

endmodule

// ==== src/tick_divider.sv ====
module tick_divider #(
  parameter int tick_div = stopwatch_pkg::TICK_DIV_DEFAULT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  stopwatch_pkg::ctrl_t ctrl,
  output logic                 tick
);

  localparam int PHASE_W = (tick_div > 1) ? $clog2(tick_div) : 1;

  logic [PHASE_W-1:0] phase;
  logic               last;

  assign last = (phase == PHASE_W'(tick_div - 1));
  assign tick = ctrl.count_en & last; // one cycle per wrap

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (ctrl.clear) begin
      phase <= '0;
    end else if (ctrl.count_en) begin
      phase <= last ? '0 : phase + 1'b1;
    end
  end

endmodule

// ==== src/stopwatch_top.sv ====
module stopwatch_top #(
  parameter int tick_div = stopwatch_pkg::TICK_DIV_DEFAULT
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  stopwatch_pkg::buttons_t  buttons,
  output stopwatch_pkg::time_bcd_t display,
  output logic                     running
);

  import stopwatch_pkg::*;

  buttons_t press; // one-cycle button strobes
  ctrl_t    ctrl;
  logic     tick;  // count strobe

  button_pulse u_button_pulse (
    .clk   (clk),
    .rst_n (rst_n),
    .level (buttons),
    .press (press)
  );

  stopwatch_ctrl u_stopwatch_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .press (press),
    .ctrl  (ctrl)
  );

  tick_divider #(
    .tick_div (tick_div)
  ) u_tick_divider (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl),
    .tick  (tick)
  );

  lap_counter u_lap_counter (
    .clk     (clk),
    .rst_n   (rst_n),
    .tick    (tick),
    .ctrl    (ctrl),
    .display (display)
  );

  assign running = ctrl.count_en;

endmodule

// ==== tb/clk_gen.sv ====
module clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int half_period  = 2; // period of 4
  localparam int reset_cycles = 3;

  initial begin
    clk = 1'b0;
    forever begin
      #half_period clk = ~clk;
    end
  end

  initial begin
    rst_n = 1'b0;
    #(2 * half_period * reset_cycles);
    rst_n = 1'b1; // released on a falling edge
  end

endmodule

// ==== tb/stopwatch_tb.sv ====
module stopwatch_tb;

  import stopwatch_pkg::*;

  localparam int          tick_div    = 2;  // one second every two cycles
  localparam int          fields      = 6;  // columns per golden line
  localparam int          max_steps   = 64;
  localparam logic [31:0] end_mark    = 32'hf;
  localparam string       golden_path = "tb/stopwatch_golden.txt";

  // golden columns
  localparam int col_pattern = 0;
  localparam int col_hold    = 1;
  localparam int col_wait    = 2;
  localparam int col_display = 3;
  localparam int col_running = 4;
  localparam int col_order   = 5;

  logic        clk;
  logic        rst_n;
  buttons_t    buttons;
  time_bcd_t   display;
  logic        running;

  logic [31:0] golden [0:fields*max_steps-1];
  int          step_count;
  int          cycle_limit = 1_000_000; // replaced once the golden file is read
  int          cycles      = 0;
  int          mismatches  = 0;
  int          other_errors = 0;

  clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  stopwatch_top #(
    .tick_div (tick_div)
  ) DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .buttons (buttons),
    .display (display),
    .running (running)
  );

  function automatic logic [31:0] golden_field(input int step, input int col);
    return golden[step*fields + col];
  endfunction

  // steps up to the end marker line
  function automatic int count_steps();
    int n;
    n = 0;
    while ((n < max_steps) && (golden_field(n, col_pattern) != end_mark)) begin
      n++;
    end
    return n;
  endfunction

  // all hold and wait cycles, room for the random gaps, plus some slack
  function automatic int limit_from_golden(input int steps);
    int total;
    total = 0;
    for (int i = 0; i < steps; i++) begin
      total += golden_field(i, col_hold) + golden_field(i, col_wait);
    end
    return total + 3 * steps + 100;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_outputs(input int step, input time_bcd_t exp_display,
                               input logic exp_running);
    assert (display === exp_display) else begin
      $display("mismatch at time %0t step %0d: display got %h%h:%h%h expected %h%h:%h%h",
               $time, step,
               display.min_tens, display.min_ones, display.sec_tens, display.sec_ones,
               exp_display.min_tens, exp_display.min_ones,
               exp_display.sec_tens, exp_display.sec_ones);
      mismatches++;
    end
    assert (running === exp_running) else begin
      $display("mismatch at time %0t step %0d: running got %b expected %b",
               $time, step, running, exp_running);
      mismatches++;
    end
  endtask

  // press, release, wait, then compare
  task automatic run_step(input int step);
    logic [31:0] pattern;
    logic [31:0] hold_cycles;
    logic [31:0] wait_cycles;
    logic [31:0] exp_display;
    logic [31:0] exp_running;
    logic [31:0] order_only;
    int          gap;
    pattern     = golden_field(step, col_pattern);
    hold_cycles = golden_field(step, col_hold);
    wait_cycles = golden_field(step, col_wait);
    exp_display = golden_field(step, col_display);
    exp_running = golden_field(step, col_running);
    order_only  = golden_field(step, col_order);
    gap = 0;
    if (order_only[0]) begin
      gap = $urandom % 4; // watch is stopped, so timing does not matter
    end
    idle_cycles(gap);
    buttons = buttons_t'(pattern[1:0]);
    idle_cycles(hold_cycles);
    buttons = '0;
    idle_cycles(wait_cycles);
    check_outputs(step, time_bcd_t'(exp_display[15:0]), exp_running[0]);
  endtask

  task automatic print_counts();
    $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
  endtask

  initial begin
    buttons = '0;
    void'($urandom(32'h4495_29af));
    for (int i = 0; i < fields*max_steps; i++) begin
      golden[i] = end_mark; // a missing file reads as an empty table
    end
    $readmemh(golden_path, golden);
    step_count  = count_steps();
    cycle_limit = limit_from_golden(step_count);
    if (step_count == 0) begin
      $display("the golden file holds no steps, nothing was tested");
      other_errors++;
    end
    @(posedge rst_n);
    @(negedge clk);
    for (int i = 0; i < step_count; i++) begin
      run_step(i);
    end
    print_counts();
    if ((mismatches == 0) && (other_errors == 0)) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
      other_errors++;
      print_counts();
      $display("Something failed");
      $finish;
    end
  end

endmodule

// ==== tb/stopwatch_golden.txt ====
// columns, all hex: pattern hold wait display running order_only
// pattern 2 = start_stop, 1 = lap_reset, 0 = none, f ends the table
// display is mm:ss as four BCD digits, order_only steps may get a random gap

// reset value, lap_reset in IDLE is ignored
0 0 4 0000 0 0
1 2 8 0000 0 1

// start, seconds tens carry, minute carry
2 2 14 0009 1 1
0 0 2 0010 1 0
0 0 62 0059 1 0
0 0 2 0100 1 0

// stop holds over a long wait
2 2 a 0102 0 0
0 0 28 0102 0 0

// resume from the same value
2 2 14 0111 1 1

// lap freezes, count goes on underneath
1 2 14 0112 1 0
0 0 14 0112 1 0
1 2 a 0138 1 0

// lap again, then stop out of LAP shows the live time
1 2 a 0139 1 0
2 2 a 0146 0 0

// lap_reset while stopped clears
1 2 a 0000 0 1
0 0 a 0000 0 0

// long run up to saturation
2 2 4b2 1000 1 1
0 0 176c 5958 1 0
0 0 2 5959 1 0
0 0 c8 5959 1 0
2 2 a 5959 0 0
1 2 a 0000 0 1

f 0 0 0 0 0

// ==== verilog.f ====
src/stopwatch_pkg.sv
src/bcd_digit_counter.sv
src/lap_counter.sv
src/button_pulse.sv
src/stopwatch_ctrl.sv
src/tick_divider.sv
src/stopwatch_top.sv
tb/clk_gen.sv
tb/stopwatch_tb.sv

// ==== Bender.yml ====
package:
  name: stopwatch

sources:
  # package first, then leaf blocks, then the top level
  - src/stopwatch_pkg.sv
  - src/bcd_digit_counter.sv
  - src/lap_counter.sv
  - src/button_pulse.sv
  - src/stopwatch_ctrl.sv
  - src/tick_divider.sv
  - src/stopwatch_top.sv

  - target: test
    files:
      - tb/clk_gen.sv
      - tb/stopwatch_tb.sv
